// File: sa_defs.svh
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

// Data widths.
`define SA_ACT_WIDTH 8
`define SA_WGT_WIDTH 8
`define SA_ACC_WIDTH 24

// Requantization shift amount up to 31.
`define SA_SHIFT_WIDTH 5

// Array dimensions.
`define SA_NUM_ROW 4
`define SA_NUM_COL 4

// Row tag on the merged result stream.
`define SA_ROW_IDX_WIDTH 2

`endif

// File: saNumPkg.sv
`include "sa_defs.svh"

package saNumPkg;

    typedef logic [`SA_ACT_WIDTH-1:0] actT;            // Unsigned activation.
    typedef logic signed [`SA_WGT_WIDTH-1:0] wgtT;     // Signed weight.

    // One extra bit so the zero-extended activation stays positive.
    typedef logic signed [`SA_ACT_WIDTH+`SA_WGT_WIDTH:0] prodT;

    typedef logic signed [`SA_ACC_WIDTH-1:0] accT;     // Channel sum.
    typedef logic [`SA_SHIFT_WIDTH-1:0] shiftT;        // Right shift amount.
    typedef logic [`SA_ACT_WIDTH-1:0] zpT;             // Output zero point.

    typedef struct packed {
        shiftT shift;
        zpT    zp;
    } quantCfgT;

endpackage

// File: saStreamPkg.sv
`include "sa_defs.svh"

package saStreamPkg;

    import saNumPkg::*;

    typedef logic [`SA_ROW_IDX_WIDTH-1:0] rowIdxT;     // Row tag.

    // Activation beat, west to east.
    typedef struct packed {
        actT  act;
        logic chnLast;                                 // Last channel of a tile.
    } actBeatT;

    // Weight beat, north to south.
    typedef struct packed {
        wgtT  wgt;
        logic chnLast;
    } wgtBeatT;

    // Merged result beat.
    typedef struct packed {
        rowIdxT row;
        actT    act;
    } psumBeatT;

endpackage

// File: pe.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module pe
    import saNumPkg::*;
    import saStreamPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  quantCfgT cfg,

    input  actBeatT  westIn,
    input  logic     westVld,
    output logic     westRdy,

    input  wgtBeatT  northIn,
    input  logic     northVld,
    output logic     northRdy,

    output actBeatT  eastOut,
    output logic     eastVld,
    input  logic     eastRdy,

    output wgtBeatT  southOut,
    output logic     southVld,
    input  logic     southRdy,

    output actT      result,
    output logic     resultVld,
    input  logic     resultRdy
);

    localparam int ACT_MAX = (1 << `SA_ACT_WIDTH) - 1;

    logic eastFree;
    logic southFree;
    logic resultFree;
    logic isLast;
    logic fire;

    prodT product;
    accT  accQ;
    accT  sum;
    accT  shifted;
    logic signed [`SA_ACC_WIDTH:0] biased;             // Room for the zero point.
    actT  quant;

    // A stage is free when empty or drained in this cycle.
    assign eastFree   = !eastVld || eastRdy;
    assign southFree  = !southVld || southRdy;
    assign resultFree = !resultVld || resultRdy;

    // West and north flags match by contract.
    assign isLast = westIn.chnLast;

    assign westRdy  = northVld && eastFree && southFree && (!isLast || resultFree);
    assign northRdy = westVld && eastFree && southFree && (!isLast || resultFree);
    assign fire     = westVld && westRdy;

    // Activation is zero-extended, weight sign-extended.
    assign product = $signed({1'b0, westIn.act}) * northIn.wgt;
    assign sum     = accQ + product;

    // Requantize the finished sum.
    assign shifted = sum >>> cfg.shift;
    assign biased  = shifted + $signed({{(`SA_ACC_WIDTH-`SA_ACT_WIDTH+1){1'b0}}, cfg.zp});

    always_comb begin
        if (biased < 0) begin
            quant = '0;                                // Clamp low.
        end else if (biased > ACT_MAX) begin
            quant = actT'(ACT_MAX);                    // Clamp high.
        end else begin
            quant = biased[`SA_ACT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eastVld   <= 1'b0;
            southVld  <= 1'b0;
            resultVld <= 1'b0;
            accQ      <= '0;
        end else begin
            if (fire) begin
                eastVld <= 1'b1;
            end else if (eastRdy) begin
                eastVld <= 1'b0;
            end

            if (fire) begin
                southVld <= 1'b1;
            end else if (southRdy) begin
                southVld <= 1'b0;
            end

            if (fire && isLast) begin
                resultVld <= 1'b1;
            end else if (resultRdy) begin
                resultVld <= 1'b0;
            end

            if (fire) begin
                accQ <= isLast ? '0 : sum;             // Next tile starts from zero.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            eastOut  <= westIn;
            southOut <= northIn;
        end
        if (fire && isLast) begin
            result <= quant;
        end
    end

endmodule

// File: peRow.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module peRow
    import saNumPkg::*;
    import saStreamPkg::*;
#(
    parameter int NUM_COL = `SA_NUM_COL
) (
    input  logic                   clk,
    input  logic                   reset,
    input  quantCfgT               cfg,

    input  actBeatT                westIn,
    input  logic                   westVld,
    output logic                   westRdy,
    output actBeatT                eastOut,
    output logic                   eastVld,
    input  logic                   eastRdy,

    input  wgtBeatT [NUM_COL-1:0]  northIn,
    input  logic    [NUM_COL-1:0]  northVld,
    output logic    [NUM_COL-1:0]  northRdy,
    output wgtBeatT [NUM_COL-1:0]  southOut,
    output logic    [NUM_COL-1:0]  southVld,
    input  logic    [NUM_COL-1:0]  southRdy,

    output actT                    rowResult,
    output logic                   rowResultVld,
    input  logic                   rowResultRdy
);

    localparam int PTR_W = (NUM_COL > 1) ? $clog2(NUM_COL) : 1;

    actBeatT [NUM_COL:0]   actBus;                     // Entry c feeds PE c.
    logic    [NUM_COL:0]   actVld;
    logic    [NUM_COL:0]   actRdy;

    actT     [NUM_COL-1:0] peResult;
    logic    [NUM_COL-1:0] peResultVld;
    logic    [NUM_COL-1:0] peResultRdy;

    logic    [PTR_W-1:0]   colPtr;

    assign actBus[0] = westIn;
    assign actVld[0] = westVld;
    assign westRdy   = actRdy[0];

    assign eastOut         = actBus[NUM_COL];
    assign eastVld         = actVld[NUM_COL];
    assign actRdy[NUM_COL] = eastRdy;

    for (genvar c = 0; c < NUM_COL; c++) begin : col
        pe uPe (
            .clk       (clk),
            .reset     (reset),
            .cfg       (cfg),
            .westIn    (actBus[c]),
            .westVld   (actVld[c]),
            .westRdy   (actRdy[c]),
            .northIn   (northIn[c]),
            .northVld  (northVld[c]),
            .northRdy  (northRdy[c]),
            .eastOut   (actBus[c+1]),
            .eastVld   (actVld[c+1]),
            .eastRdy   (actRdy[c+1]),
            .southOut  (southOut[c]),
            .southVld  (southVld[c]),
            .southRdy  (southRdy[c]),
            .result    (peResult[c]),
            .resultVld (peResultVld[c]),
            .resultRdy (peResultRdy[c])
        );
    end

    // Results leave in column order.
    assign rowResult    = peResult[colPtr];
    assign rowResultVld = peResultVld[colPtr];

    always_comb begin
        peResultRdy         = '0;
        peResultRdy[colPtr] = rowResultRdy;            // Only the selected PE drains.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            colPtr <= '0;
        end else if (rowResultVld && rowResultRdy) begin
            colPtr <= (colPtr == PTR_W'(NUM_COL - 1)) ? '0 : colPtr + 1'b1;
        end
    end

endmodule

// File: peBank.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module peBank
    import saNumPkg::*;
    import saStreamPkg::*;
#(
    parameter int NUM_ROW = `SA_NUM_ROW,
    parameter int NUM_COL = `SA_NUM_COL
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfgVld,
    input  quantCfgT               cfg,

    input  actBeatT [NUM_ROW-1:0]  actIn,
    input  logic    [NUM_ROW-1:0]  actInVld,
    output logic    [NUM_ROW-1:0]  actInRdy,
    output actBeatT [NUM_ROW-1:0]  actOut,
    output logic    [NUM_ROW-1:0]  actOutVld,
    input  logic    [NUM_ROW-1:0]  actOutRdy,

    input  wgtBeatT [NUM_COL-1:0]  wgtIn,
    input  logic    [NUM_COL-1:0]  wgtInVld,
    output logic    [NUM_COL-1:0]  wgtInRdy,
    output wgtBeatT [NUM_COL-1:0]  wgtOut,
    output logic    [NUM_COL-1:0]  wgtOutVld,
    input  logic    [NUM_COL-1:0]  wgtOutRdy,

    output actT     [NUM_ROW-1:0]  rowResult,
    output logic    [NUM_ROW-1:0]  rowResultVld,
    input  logic    [NUM_ROW-1:0]  rowResultRdy
);

    quantCfgT cfgQ;

    // Weight bus r enters row r; bus NUM_ROW is the south edge.
    wgtBeatT [NUM_ROW:0][NUM_COL-1:0] wgtBus;
    logic    [NUM_ROW:0][NUM_COL-1:0] wgtVld;
    logic    [NUM_ROW:0][NUM_COL-1:0] wgtRdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfgQ <= '0;
        end else if (cfgVld) begin
            cfgQ <= cfg;                               // Used from the next cycle.
        end
    end

    assign wgtBus[0] = wgtIn;
    assign wgtVld[0] = wgtInVld;
    assign wgtInRdy  = wgtRdy[0];

    assign wgtOut          = wgtBus[NUM_ROW];
    assign wgtOutVld       = wgtVld[NUM_ROW];
    assign wgtRdy[NUM_ROW] = wgtOutRdy;

    for (genvar r = 0; r < NUM_ROW; r++) begin : row
        peRow #(
            .NUM_COL (NUM_COL)
        ) uPeRow (
            .clk          (clk),
            .reset        (reset),
            .cfg          (cfgQ),
            .westIn       (actIn[r]),
            .westVld      (actInVld[r]),
            .westRdy      (actInRdy[r]),
            .eastOut      (actOut[r]),
            .eastVld      (actOutVld[r]),
            .eastRdy      (actOutRdy[r]),
            .northIn      (wgtBus[r]),
            .northVld     (wgtVld[r]),
            .northRdy     (wgtRdy[r]),
            .southOut     (wgtBus[r+1]),
            .southVld     (wgtVld[r+1]),
            .southRdy     (wgtRdy[r+1]),
            .rowResult    (rowResult[r]),
            .rowResultVld (rowResultVld[r]),
            .rowResultRdy (rowResultRdy[r])
        );
    end

endmodule

// File: psumMerge.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module psumMerge
    import saNumPkg::*;
    import saStreamPkg::*;
#(
    parameter int NUM_ROW = `SA_NUM_ROW
) (
    input  logic                 clk,
    input  logic                 reset,

    input  actT  [NUM_ROW-1:0]   rowResult,
    input  logic [NUM_ROW-1:0]   rowResultVld,
    output logic [NUM_ROW-1:0]   rowResultRdy,

    output psumBeatT             psumOut,
    output logic                 psumOutVld,
    input  logic                 psumOutRdy
);

    rowIdxT lastGrant;                                 // Search starts after this row.
    rowIdxT grantIdx;
    logic   grantVld;
    logic   outFree;
    logic   take;

    // Round-robin pick over the valid rows.
    always_comb begin
        int idx;
        grantVld = 1'b0;
        grantIdx = '0;
        for (int i = 1; i <= NUM_ROW; i++) begin
            idx = (int'(lastGrant) + i) % NUM_ROW;
            if (!grantVld && rowResultVld[idx]) begin
                grantVld = 1'b1;
                grantIdx = rowIdxT'(idx);
            end
        end
    end

    // Output register reloads in the cycle it drains.
    assign outFree = !psumOutVld || psumOutRdy;
    assign take    = grantVld && outFree;

    always_comb begin
        rowResultRdy           = '0;
        rowResultRdy[grantIdx] = take;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            psumOutVld <= 1'b0;
            lastGrant  <= rowIdxT'(NUM_ROW - 1);       // Row 0 wins first.
        end else begin
            if (take) begin
                psumOutVld <= 1'b1;
                lastGrant  <= grantIdx;
            end else if (psumOutRdy) begin
                psumOutVld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            psumOut.row <= grantIdx;
            psumOut.act <= rowResult[grantIdx];
        end
    end

endmodule

// File: systolicTop.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module systolicTop
    import saNumPkg::*;
    import saStreamPkg::*;
#(
    parameter int NUM_ROW = `SA_NUM_ROW,
    parameter int NUM_COL = `SA_NUM_COL
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   cfgVld,
    input  quantCfgT               cfg,

    input  actBeatT [NUM_ROW-1:0]  actIn,
    input  logic    [NUM_ROW-1:0]  actInVld,
    output logic    [NUM_ROW-1:0]  actInRdy,
    input  wgtBeatT [NUM_COL-1:0]  wgtIn,
    input  logic    [NUM_COL-1:0]  wgtInVld,
    output logic    [NUM_COL-1:0]  wgtInRdy,

    output actBeatT [NUM_ROW-1:0]  actOut,
    output logic    [NUM_ROW-1:0]  actOutVld,
    input  logic    [NUM_ROW-1:0]  actOutRdy,
    output wgtBeatT [NUM_COL-1:0]  wgtOut,
    output logic    [NUM_COL-1:0]  wgtOutVld,
    input  logic    [NUM_COL-1:0]  wgtOutRdy,

    output psumBeatT               psumOut,
    output logic                   psumOutVld,
    input  logic                   psumOutRdy
);

    // One result stream per row.
    actT  [NUM_ROW-1:0] rowResult;
    logic [NUM_ROW-1:0] rowResultVld;
    logic [NUM_ROW-1:0] rowResultRdy;

    peBank #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) uPeBank (
        .clk          (clk),
        .reset        (reset),
        .cfgVld       (cfgVld),
        .cfg          (cfg),
        .actIn        (actIn),
        .actInVld     (actInVld),
        .actInRdy     (actInRdy),
        .actOut       (actOut),
        .actOutVld    (actOutVld),
        .actOutRdy    (actOutRdy),
        .wgtIn        (wgtIn),
        .wgtInVld     (wgtInVld),
        .wgtInRdy     (wgtInRdy),
        .wgtOut       (wgtOut),
        .wgtOutVld    (wgtOutVld),
        .wgtOutRdy    (wgtOutRdy),
        .rowResult    (rowResult),
        .rowResultVld (rowResultVld),
        .rowResultRdy (rowResultRdy)
    );

    psumMerge #(
        .NUM_ROW (NUM_ROW)
    ) uPsumMerge (
        .clk          (clk),
        .reset        (reset),
        .rowResult    (rowResult),
        .rowResultVld (rowResultVld),
        .rowResultRdy (rowResultRdy),
        .psumOut      (psumOut),
        .psumOutVld   (psumOutVld),
        .psumOutRdy   (psumOutRdy)
    );

endmodule

// File: tb_systolicTop.sv
`timescale 1ns/1ns
`include "sa_defs.svh"

module tb_systolicTop
    import saNumPkg::*;
    import saStreamPkg::*;
();

    localparam int NUM_ROW      = `SA_NUM_ROW;
    localparam int NUM_COL      = `SA_NUM_COL;
    localparam int NUM_TILES    = 4;
    localparam int GOLDEN_DEPTH = 256;

    logic                  clk;
    logic                  reset      = 1'b1;
    logic                  cfgVld     = 1'b0;
    quantCfgT              cfg        = '0;
    actBeatT [NUM_ROW-1:0] actIn      = '0;
    logic    [NUM_ROW-1:0] actInVld   = '0;
    logic    [NUM_ROW-1:0] actInRdy;
    wgtBeatT [NUM_COL-1:0] wgtIn      = '0;
    logic    [NUM_COL-1:0] wgtInVld   = '0;
    logic    [NUM_COL-1:0] wgtInRdy;
    actBeatT [NUM_ROW-1:0] actOut;
    logic    [NUM_ROW-1:0] actOutVld;
    logic    [NUM_ROW-1:0] actOutRdy  = '1;
    wgtBeatT [NUM_COL-1:0] wgtOut;
    logic    [NUM_COL-1:0] wgtOutVld;
    logic    [NUM_COL-1:0] wgtOutRdy  = '1;
    psumBeatT              psumOut;
    logic                  psumOutVld;
    logic                  psumOutRdy = 1'b1;

    logic [7:0] golden [0:GOLDEN_DEPTH-1];
    int         tileShift [NUM_TILES];
    int         tileZp [NUM_TILES];
    int         tileK [NUM_TILES];
    int         tileBase [NUM_TILES];                  // First activation of each tile.
    bit         goldenOk;

    actBeatT actFeedQ [NUM_ROW][$];                    // Beats still to be driven.
    actBeatT actExpQ [NUM_ROW][$];                     // Beats expected on actOut.
    wgtBeatT wgtFeedQ [NUM_COL][$];
    wgtBeatT wgtExpQ [NUM_COL][$];
    actT     resExpQ [NUM_ROW][$];
    int      resCount [NUM_ROW] = '{default: 0};

    logic [NUM_ROW-1:0] actFire   = '0;                // Handshakes of the last edge.
    logic [NUM_COL-1:0] wgtFire   = '0;
    logic               stallOn   = 1'b0;
    logic [31:0]        lcgState  = 32'd89752;
    int                 errCount   = 0;
    int                 checkCount = 0;
    int                 cycleCnt   = 0;
    int                 cycleLimit = 0;

    systolicTop u_dut (
        .clk        (clk),
        .reset      (reset),
        .cfgVld     (cfgVld),
        .cfg        (cfg),
        .actIn      (actIn),
        .actInVld   (actInVld),
        .actInRdy   (actInRdy),
        .wgtIn      (wgtIn),
        .wgtInVld   (wgtInVld),
        .wgtInRdy   (wgtInRdy),
        .actOut     (actOut),
        .actOutVld  (actOutVld),
        .actOutRdy  (actOutRdy),
        .wgtOut     (wgtOut),
        .wgtOutVld  (wgtOutVld),
        .wgtOutRdy  (wgtOutRdy),
        .psumOut    (psumOut),
        .psumOutVld (psumOutVld),
        .psumOutRdy (psumOutRdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;                         // Upper bits are the better ones.
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errCount++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic readGolden();
        int ptr;
        int beats;
        $readmemh("sa_golden.txt", golden);
        goldenOk = (golden[0] === 8'(NUM_TILES));
        ptr = 1;
        beats = 0;
        for (int t = 0; t < NUM_TILES; t++) begin
            tileShift[t] = int'(golden[ptr]);
            tileZp[t]    = int'(golden[ptr + 1]);
            tileK[t]     = int'(golden[ptr + 2]);
            tileBase[t]  = ptr + 3;
            if (tileK[t] < 1) begin
                goldenOk = 1'b0;
            end
            beats = beats + tileK[t] * (NUM_ROW + NUM_COL) + NUM_ROW * NUM_COL;
            ptr = tileBase[t] + tileK[t] * (NUM_ROW + NUM_COL) + NUM_ROW * NUM_COL;
        end
        if (ptr > GOLDEN_DEPTH) begin
            goldenOk = 1'b0;
        end
        cycleLimit = 40 * beats + 200;
    endtask

    // Queues one tile for driving and for checking.
    task automatic loadTile(input int t);
        actBeatT aBeat;
        wgtBeatT wBeat;
        int      k;
        int      wgtBase;
        int      expBase;
        k       = tileK[t];
        wgtBase = tileBase[t] + NUM_ROW * k;
        expBase = wgtBase + NUM_COL * k;
        for (int r = 0; r < NUM_ROW; r++) begin
            for (int i = 0; i < k; i++) begin
                aBeat.act     = golden[tileBase[t] + r * k + i];
                aBeat.chnLast = (i == k - 1);
                actFeedQ[r].push_back(aBeat);
                actExpQ[r].push_back(aBeat);
            end
        end
        for (int c = 0; c < NUM_COL; c++) begin
            for (int i = 0; i < k; i++) begin
                wBeat.wgt     = golden[wgtBase + c * k + i];
                wBeat.chnLast = (i == k - 1);
                wgtFeedQ[c].push_back(wBeat);
                wgtExpQ[c].push_back(wBeat);
            end
        end
        for (int r = 0; r < NUM_ROW; r++) begin
            for (int c = 0; c < NUM_COL; c++) begin
                resExpQ[r].push_back(golden[expBase + r * NUM_COL + c]);
            end
        end
    endtask

    function automatic bit allDrained();
        bit done;
        done = 1'b1;
        for (int r = 0; r < NUM_ROW; r++) begin
            if (actExpQ[r].size() != 0 || resExpQ[r].size() != 0) begin
                done = 1'b0;
            end
        end
        for (int c = 0; c < NUM_COL; c++) begin
            if (wgtExpQ[c].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic applyConfig(input int t);
        @(negedge clk);
        cfg.shift = shiftT'(tileShift[t]);
        cfg.zp    = zpT'(tileZp[t]);
        cfgVld    = 1'b1;
        @(negedge clk);
        cfgVld    = 1'b0;
    endtask

    task automatic waitDrained();
        @(negedge clk);
        while (!allDrained()) begin
            @(negedge clk);
        end
    endtask

    // Input streams and output back-pressure.
    always @(negedge clk) begin
        for (int r = 0; r < NUM_ROW; r++) begin
            if (actFire[r]) begin
                void'(actFeedQ[r].pop_front());
            end
            if (!actInVld[r] || actFire[r]) begin
                if (actFeedQ[r].size() > 0 && (nextRand() % 4) != 0) begin
                    actIn[r]    = actFeedQ[r][0];
                    actInVld[r] = 1'b1;
                end else begin
                    actInVld[r] = 1'b0;                // Random gap.
                end
            end
        end
        for (int c = 0; c < NUM_COL; c++) begin
            if (wgtFire[c]) begin
                void'(wgtFeedQ[c].pop_front());
            end
            if (!wgtInVld[c] || wgtFire[c]) begin
                if (wgtFeedQ[c].size() > 0 && (nextRand() % 4) != 0) begin
                    wgtIn[c]    = wgtFeedQ[c][0];
                    wgtInVld[c] = 1'b1;
                end else begin
                    wgtInVld[c] = 1'b0;
                end
            end
        end
        if (stallOn) begin
            psumOutRdy = (nextRand() % 3) != 0;
            for (int r = 0; r < NUM_ROW; r++) begin
                actOutRdy[r] = (nextRand() % 4) != 0;
            end
            for (int c = 0; c < NUM_COL; c++) begin
                wgtOutRdy[c] = (nextRand() % 4) != 0;
            end
        end else begin
            psumOutRdy = 1'b1;
            actOutRdy  = '1;
            wgtOutRdy  = '1;
        end
    end

    // Handshakes and output checks on the rising edge.
    always @(posedge clk) begin
        actBeatT expAct;
        wgtBeatT expWgt;
        actT     expRes;
        actFire = actInVld & actInRdy;
        wgtFire = wgtInVld & wgtInRdy;
        if (!reset) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                if (actOutVld[r] && actOutRdy[r]) begin
                    if (actExpQ[r].size() == 0) begin
                        errCount++;
                        $display("Row %0d forwarded an activation that was never fed", r);
                    end else begin
                        expAct = actExpQ[r].pop_front();
                        checkValue($sformatf("actOut[%0d]", r), actOut[r], expAct);
                    end
                end
            end
            for (int c = 0; c < NUM_COL; c++) begin
                if (wgtOutVld[c] && wgtOutRdy[c]) begin
                    if (wgtExpQ[c].size() == 0) begin
                        errCount++;
                        $display("Column %0d forwarded a weight that was never fed", c);
                    end else begin
                        expWgt = wgtExpQ[c].pop_front();
                        checkValue($sformatf("wgtOut[%0d]", c), wgtOut[c], expWgt);
                    end
                end
            end
            if (psumOutVld && psumOutRdy) begin
                resCount[psumOut.row]++;
                if (resExpQ[psumOut.row].size() == 0) begin
                    errCount++;
                    $display("Row %0d sent a result that no tile accounts for", psumOut.row);
                end else begin
                    expRes = resExpQ[psumOut.row].pop_front();
                    checkValue($sformatf("psumOut.act row %0d", psumOut.row),
                               psumOut.act, expRes);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleLimit > 0 && cycleCnt > cycleLimit) begin
            $display("Timeout, the tiles did not complete within %0d cycles", cycleLimit);
            $display("Checks: %0d, errors: %0d", checkCount, errCount + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        readGolden();
        if (!goldenOk) begin
            $display("The golden file sa_golden.txt is missing or malformed");
            $display("Checks: %0d, errors: %0d", checkCount, errCount + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;

            // Tile 1 with the outputs always ready.
            applyConfig(0);
            @(posedge clk);
            loadTile(0);
            waitDrained();

            // Tiles 2 and 3 back to back under random stalls.
            @(posedge clk);
            stallOn = 1'b1;
            if (tileShift[2] != tileShift[1] || tileZp[2] != tileZp[1]) begin
                errCount++;
                $display("Tiles 2 and 3 need one shift and zero point to run back to back");
            end
            applyConfig(1);
            @(posedge clk);
            loadTile(1);
            loadTile(2);
            waitDrained();

            // Tile 4 after a new configuration.
            applyConfig(3);
            @(posedge clk);
            loadTile(3);
            waitDrained();
            repeat (8) @(negedge clk);                 // Catch stray results.

            for (int r = 0; r < NUM_ROW; r++) begin
                checkValue($sformatf("result count row %0d", r), resCount[r],
                           NUM_TILES * NUM_COL);
            end
            $display("Checks: %0d, errors: %0d", checkCount, errCount);
            if (errCount == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+.
saNumPkg.sv
saStreamPkg.sv
pe.sv
peRow.sv
peBank.sv
psumMerge.sv
systolicTop.sv
tb_systolicTop.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the systolic array testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_systolicTop \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

// File: sa_golden.txt
// Per tile: shift zp K, then K activations per row, then K weights per column
// (two's complement), then the expected results of each row in column order.
04
// Tile 1, basic.
02 0a 02
01 02
03 04
0a 14
64 32
01 01
02 ff
04 03
fe 05
0a 0a 0c 0c
0b 0a 10 0d
11 0a 23 1e
2f 2f 93 16
// Tile 2, under output stalls.
03 80 03
08 10 18
00 00 00
ff 01 02
05 06 07
01 02 03
ff ff ff
00 08 00
0a fb 01
8e 7a 90 83
80 80 80 80
a0 5f 81 ff
84 7d 86 83
// Tile 3, saturates at both limits.
03 80 02
ff ff
c8 64
01 01
80 00
7f 7f
80 80
01 ff
ff 02
ff 00 80 9f
ff 00 8c 80
9f 60 80 80
ff 00 90 70
// Tile 4, new shift and zero point.
01 20 03
01 02 03
04 05 06
07 08 09
0a 0b 0c
01 00 00
00 01 00
01 01 01
fd 00 02
20 21 23 21
22 22 27 20
23 24 2c 1e
25 25 30 1d
